//--- dataFilter.sv
// Combinational; fine window is half-open [winLow, winHigh) and winHigh carries one extra bit
`default_nettype none
`timescale 1ns/100ps

`include "sifh_defines.svh"

module dataFilter (
    input  sifhDataPkg::sampleT                  data,
    input  sifhDataPkg::pixelT                   pixel,
    input  sifhCtrlPkg::passT                    pass,
    input  wire [`SIFH_PIXELS*`SIFH_NP-1:0]      winLow,
    input  wire [`SIFH_PIXELS*(`SIFH_NP+1)-1:0]  winHigh,
    input  wire [`SIFH_PIXELS*`SIFH_NP-1:0]      offset,
    output sifhDataPkg::binT                     bin,
    output logic                                 keep
);

    sifhDataPkg::sampleT     lowSel;    // Window of the current pixel
    sifhDataPkg::sampleT     offSel;
    sifhDataPkg::sampleT     rel;       // Sample relative to offset
    logic [`SIFH_NP:0]       highSel;

    always_comb begin
        lowSel  = winLow[int'(pixel)*`SIFH_NP +: `SIFH_NP];
        highSel = winHigh[int'(pixel)*(`SIFH_NP+1) +: (`SIFH_NP+1)];
        offSel  = offset[int'(pixel)*`SIFH_NP +: `SIFH_NP];
        rel     = data - offSel;

        if (pass == sifhCtrlPkg::passCoarse) begin
            bin  = data[`SIFH_NP-1 -: `SIFH_NB];   // Top bits pick the coarse bin
            keep = 1'b1;
        end else begin
            // Low bits after offset removal, window spans exactly SIFH_BINS values
            bin  = rel[`SIFH_NB-1:0];
            keep = (data >= lowSel) && ({1'b0, data} < highSel);
        end
    end

endmodule

`default_nettype wire

//--- frameSequencer.sv
// Fixed sample order (acq, pixel, sample); wrEn is dropped for the 3 busy cycles after a pass
`default_nettype none
`timescale 1ns/100ps

`include "sifh_defines.svh"

module frameSequencer (
    input  wire                       clk,
    input  wire                       combin_res,
    input  wire                       wrEn,
    output sifhDataPkg::pixelT        pixel,      // Current pixel, doubles as counter
    output sifhCtrlPkg::passT         pass,
    output logic                      accept,
    output logic                      passEnd,    // Peaks are final in this cycle
    output logic                      clear,      // Histogram and peak wipe
    output logic                      busy
);

    localparam int smpW = $clog2(`SIFH_DATA_NUM);
    localparam int acqW = $clog2(`SIFH_ACQ_NUM);

    sifhCtrlPkg::seqStateT state;
    logic [smpW-1:0]       smpCnt;   // Sample within pixel
    logic [acqW-1:0]       acqCnt;   // Acquisition within pass
    logic [1:0]            dly;      // Flush step
    logic                  lastSample;

    assign accept = wrEn && !busy;   // Only back-pressure there is

    // Final sample of a whole pass
    assign lastSample = (smpCnt == smpW'(`SIFH_DATA_NUM - 1)) &&
                        (pixel == sifhDataPkg::pixelT'(`SIFH_PIXELS - 1)) &&
                        (acqCnt == acqW'(`SIFH_ACQ_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state   <= sifhCtrlPkg::seqRun;
            pass    <= sifhCtrlPkg::passCoarse;
            smpCnt  <= '0;
            pixel   <= '0;
            acqCnt  <= '0;
            dly     <= '0;
            busy    <= 1'b0;
            passEnd <= 1'b0;
            clear   <= 1'b0;
        end else begin
            passEnd <= 1'b0;   // Pulses by default
            clear   <= 1'b0;
            case (state)
                sifhCtrlPkg::seqRun: begin
                    if (accept) begin
                        // Nested wrap, all three roll to zero together at pass end
                        smpCnt <= smpCnt + 1'b1;
                        if (smpCnt == smpW'(`SIFH_DATA_NUM - 1)) begin
                            smpCnt <= '0;
                            pixel  <= pixel + 1'b1;
                            if (pixel == sifhDataPkg::pixelT'(`SIFH_PIXELS - 1)) begin
                                pixel  <= '0;
                                acqCnt <= acqCnt + 1'b1;
                                if (acqCnt == acqW'(`SIFH_ACQ_NUM - 1)) begin
                                    acqCnt <= '0;
                                end
                            end
                        end
                        if (lastSample) begin
                            state <= sifhCtrlPkg::seqFlush;
                            busy  <= 1'b1;
                            dly   <= '0;
                        end
                    end
                end
                sifhCtrlPkg::seqFlush: begin
                    dly <= dly + 1'b1;
                    if (dly == 2'd0) begin
                        passEnd <= 1'b1;                 // Peak update has landed
                    end
                    if (dly == 2'd1) begin
                        clear <= 1'b1;
                        pass  <= (pass == sifhCtrlPkg::passCoarse) ?
                                 sifhCtrlPkg::passFine : sifhCtrlPkg::passCoarse;
                    end
                    if (dly == 2'd2) begin
                        busy  <= 1'b0;                   // Next sample one edge later
                        state <= sifhCtrlPkg::seqRun;
                    end
                end
                default: state <= sifhCtrlPkg::seqRun;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- histogramBuilder.sv
// One write per cycle; accept and clear never meet since clear only comes while busy
`default_nettype none
`timescale 1ns/100ps

`include "sifh_defines.svh"

module histogramBuilder (
    input  wire                  clk,
    input  wire                  combin_res,
    input  wire                  accept,
    input  wire                  keep,
    input  sifhDataPkg::binT     bin,
    input  sifhDataPkg::pixelT   pixel,
    input  wire                  clear,
    output logic                 cntValid,
    output sifhDataPkg::pixelT   cntPixel,
    output sifhDataPkg::binT     cntBin,
    output sifhDataPkg::countT   cnt
);

    localparam int depth = `SIFH_PIXELS * `SIFH_BINS;
    localparam int addrW = $clog2(depth);

    // **************************************************
    // Bin RAM, one row per pixel and bin
    // **************************************************
    sifhDataPkg::countT mem [depth];
    logic [depth-1:0]   binValid;         // Stale entries read as zero

    logic [addrW-1:0]   addr;
    logic               wrHit;
    sifhDataPkg::countT curCnt;
    sifhDataPkg::countT nxtCnt;

    assign addr   = {pixel, bin};                          // Pixel selects the row block
    assign wrHit  = accept && keep;
    assign curCnt = binValid[addr] ? mem[addr] : '0;
    assign nxtCnt = sifhDataPkg::countT'(curCnt + 1'b1);

    // Read-modify-write in the accept cycle
    always_ff @(posedge clk) begin
        if (wrHit) begin
            mem[addr] <= nxtCnt;
        end
    end

    // **************************************************
    // Valid bits and count strobe
    // **************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            cntValid <= 1'b0;
        end else begin
            cntValid <= wrHit;
            if (clear) begin
                binValid <= '0;                  // Whole histogram gone in one cycle
            end else if (wrHit) begin
                binValid[addr] <= 1'b1;
            end
        end
    end

    // Count payload for the peak search
    always_ff @(posedge clk) begin
        if (wrHit) begin
            cntPixel <= pixel;
            cntBin   <= bin;
            cnt      <= nxtCnt;
        end
    end

endmodule

`default_nettype wire

//--- peakDetector.sv
// Strictly-greater update so ties hold the first bin to reach a count; empty pixel reports bin 0
`default_nettype none
`timescale 1ns/100ps

`include "sifh_defines.svh"

module peakDetector (
    input  wire                                clk,
    input  wire                                combin_res,
    input  wire                                clear,
    input  wire                                cntValid,
    input  sifhDataPkg::pixelT                 cntPixel,
    input  sifhDataPkg::binT                   cntBin,
    input  sifhDataPkg::countT                 cnt,
    output logic [`SIFH_PIXELS*`SIFH_NB-1:0]   peakBins
);

    sifhDataPkg::countT maxCnt [`SIFH_PIXELS];   // Running maximum
    sifhDataPkg::binT   maxBin [`SIFH_PIXELS];   // Bin holding it

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                maxCnt[p] <= '0;
                maxBin[p] <= '0;
            end
        end else if (clear) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                maxCnt[p] <= '0;   // New pass, new search
                maxBin[p] <= '0;
            end
        end else if (cntValid && (cnt > maxCnt[cntPixel])) begin
            maxCnt[cntPixel] <= cnt;
            maxBin[cntPixel] <= cntBin;
        end
    end

    // Pixel 0 in the low bits
    always_comb begin
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            peakBins[p*`SIFH_NB +: `SIFH_NB] = maxBin[p];
        end
    end

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module sifhTb -f vlog.f -o sifhSim
./obj_dir/sifhSim | tee sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- sifhCtrlPkg.sv
// Control encodings; both enums are single-bit and toggle-friendly
`default_nettype none

package sifhCtrlPkg;

    // **************************************************
    // Pass phase
    // **************************************************
    // Coarse pass bins on top bits, fine pass on the window
    typedef enum logic {
        passCoarse = 1'b0,
        passFine   = 1'b1
    } passT;

    // **************************************************
    // Sequencer state
    // **************************************************
    typedef enum logic {
        seqRun   = 1'b0,   // Accepting samples
        seqFlush = 1'b1    // Pipeline drain and histogram clear
    } seqStateT;

endpackage

`default_nettype wire

//--- sifhDataPkg.sv
// Data-path types only; widths follow the macros in the defines header
`default_nettype none

`include "sifh_defines.svh"

package sifhDataPkg;

    // **************************************************
    // Payload types
    // **************************************************
    typedef logic [`SIFH_NP-1:0]    sampleT;  // Raw timestamp
    typedef logic [`SIFH_NB-1:0]    binT;     // Histogram bin address
    typedef logic [`SIFH_CNT_W-1:0] countT;   // Per-bin hit count

    // Pixel index, 2 bits for 4 pixels
    typedef logic [$clog2(`SIFH_PIXELS)-1:0] pixelT;

endpackage

`default_nettype wire

//--- sifhTb.sv
// Drives whole frames at a 40 ns clock; model assumes the fixed acq, pixel, sample order
`default_nettype none
`timescale 1ns/100ps

`include "sifh_defines.svh"

module sifhTb;

    localparam int smpPerPass  = `SIFH_PIXELS * `SIFH_DATA_NUM * `SIFH_ACQ_NUM;
    localparam int shiftW      = `SIFH_NP - `SIFH_NB;
    localparam int halfW       = 1 << (`SIFH_NB - 1);
    localparam int maxS        = (1 << `SIFH_NP) - 1;
    localparam int resultWait  = 8;                        // Cycles from last sample to strobe
    localparam int framesTotal = 8;                        // One each in tests 2 to 5, four in 6
    localparam int frameCyc    = 2 * (smpPerPass + 4) + resultWait;
    localparam int cycleLimit  = 2 * framesTotal * frameCyc + 200;

    logic                             clk;
    logic                             combin_res;
    logic                             wrEn;
    sifhDataPkg::sampleT              data;
    logic                             busy;
    sifhCtrlPkg::passT                pass;
    logic [`SIFH_PIXELS*`SIFH_NP-1:0] peaks;
    logic                             resultValid;

    sifhDataPkg::sampleT coarseSmp [smpPerPass];   // Stimulus per pass
    sifhDataPkg::sampleT fineSmp   [smpPerPass];
    int                  centers   [`SIFH_PIXELS]; // Cluster start per pixel
    int                  expPeak   [`SIFH_PIXELS]; // Model result
    int                  errCount  = 0;
    int                  checkCount = 0;
    int                  testCount = 0;
    int                  cycles    = 0;
    logic [31:0]         rngState  = 32'hbfe0f46a;

    sifhTop i_dut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .busy(busy), .pass(pass), .peaks(peaks), .resultValid(resultValid)
    );

    bind sifhTop sifhTop_checker i_checker (
        .clk(clk), .combin_res(combin_res), .busy(busy),
        .resultValid(resultValid), .pass(pass)
    );

    // **************************************************
    // Clock, watchdog and helpers
    // **************************************************
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("Test failed");
        $finish;
    end

    function logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
        return rngState;
    endfunction

    function automatic int pixOf(int i);
        return (i / `SIFH_DATA_NUM) % `SIFH_PIXELS;   // Pixel of sample slot i
    endfunction

    // Offsets 0,1,1,2 so the mode is one above the cluster start
    function automatic int clusterOff(int k);
        case (k % 4)
            0:       return 0;
            3:       return 2;
            default: return 1;
        endcase
    endfunction

    // Hits on +3 at 0,3,4,6; +3 reaches count 4 first
    function automatic int tieOff(int j);
        return (j == 0 || j == 3 || j == 4 || j == 6) ? 3 : 0;
    endfunction

    task automatic checkVal(input string sig, input int exp, input int got);
        checkCount++;
        assert (exp == got) else begin
            $display("error at %0t ns: %s expected %0d got %0d", $time, sig, exp, got);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int e0);
        testCount++;
        $display("%-14s done, %0d errors", name, errCount - e0);
    endtask

    // **************************************************
    // Reference model
    // **************************************************
    task automatic computeModel();
        int hist [`SIFH_PIXELS][`SIFH_BINS];
        int maxC [`SIFH_PIXELS];
        int maxB [`SIFH_PIXELS];
        int low  [`SIFH_PIXELS];
        int high [`SIFH_PIXELS];
        int p;
        int b;
        int s;
        int i;
        int center;
        for (int k = 0; k < 2; k++) begin   // 0 coarse, 1 fine
            for (p = 0; p < `SIFH_PIXELS; p++) begin
                maxC[p] = 0;
                maxB[p] = 0;
                for (b = 0; b < `SIFH_BINS; b++) begin
                    hist[p][b] = 0;
                end
            end
            for (i = 0; i < smpPerPass; i++) begin
                p = pixOf(i);
                if (k == 0) begin
                    s = int'(coarseSmp[i]);
                    b = s >> shiftW;                               // Top bits
                end else begin
                    s = int'(fineSmp[i]);
                    b = (s >= low[p] && s < high[p]) ? s - low[p] : -1;   // Drop outside
                end
                if (b >= 0) begin
                    hist[p][b]++;
                    if (hist[p][b] > maxC[p]) begin   // Strictly greater, first wins
                        maxC[p] = hist[p][b];
                        maxB[p] = b;
                    end
                end
            end
            if (k == 0) begin
                for (p = 0; p < `SIFH_PIXELS; p++) begin
                    center = maxB[p] << shiftW;
                    if (center <= halfW) begin
                        low[p] = 0;
                    end else if (center >= maxS - halfW) begin
                        low[p] = maxS + 1 - 2 * halfW;
                    end else begin
                        low[p] = center - halfW;
                    end
                    high[p] = low[p] + 2 * halfW;
                end
            end
        end
        for (p = 0; p < `SIFH_PIXELS; p++) begin
            expPeak[p] = (maxB[p] + low[p]) % (maxS + 1);
        end
    endtask

    // **************************************************
    // Frame driving
    // **************************************************
    task automatic sendPass(input bit fine, input bit junk);
        for (int i = 0; i < smpPerPass; i++) begin
            @(negedge clk);
            while (busy) begin
                wrEn = junk;   // Stray strobes during flush
                if (junk) begin
                    data = sifhDataPkg::sampleT'(nextRand() >> 8);
                end else begin
                    data = '0;
                end
                @(negedge clk);
            end
            if (i == 0) begin
                checkVal("pass", fine ? 1 : 0, int'(pass));
            end
            wrEn = 1'b1;
            data = fine ? fineSmp[i] : coarseSmp[i];
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic waitResult();
        int waited;
        int got;
        waited = 0;
        while (!resultValid && waited < resultWait) begin
            @(negedge clk);
            waited++;
        end
        checkCount++;
        assert (resultValid) else begin
            $display("no resultValid pulse within %0d cycles of the fine pass", resultWait);
            errCount++;
        end
        if (resultValid) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                got = int'(peaks[p*`SIFH_NP +: `SIFH_NP]);
                checkVal($sformatf("peaks[%0d]", p), expPeak[p], got);
            end
            @(negedge clk);
            checkVal("resultValid", 0, int'(resultValid));
        end
    endtask

    task automatic runFrame(input bit junk);
        sendPass(1'b0, junk);
        sendPass(1'b1, junk);
        computeModel();
        waitResult();
    endtask

    // Known mode, held in peaks after the strobe
    task automatic checkHand(input int delta);
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            checkVal($sformatf("peaks[%0d]", p), (centers[p] + delta) % (maxS + 1),
                     int'(peaks[p*`SIFH_NP +: `SIFH_NP]));
        end
    endtask

    task automatic buildCluster();
        for (int i = 0; i < smpPerPass; i++) begin
            coarseSmp[i] = sifhDataPkg::sampleT'(centers[pixOf(i)] + clusterOff(i));
            fineSmp[i]   = coarseSmp[i];
        end
    endtask

    // **************************************************
    // Tests
    // **************************************************
    task automatic testReset();
        int e0;
        e0 = errCount;
        checkVal("busy", 0, int'(busy));
        checkVal("resultValid", 0, int'(resultValid));
        checkVal("pass", 0, int'(pass));
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            checkVal($sformatf("peaks[%0d]", p), 0, int'(peaks[p*`SIFH_NP +: `SIFH_NP]));
        end
        reportTest("resetState", e0);
    endtask

    task automatic testMidCluster();
        int e0;
        e0 = errCount;
        centers = '{517, 1288, 2059, 2830};   // Lower half of a coarse bin
        buildCluster();
        runFrame(1'b0);
        checkHand(1);
        reportTest("midCluster", e0);
    endtask

    task automatic testClamp();
        int e0;
        e0 = errCount;
        centers = '{3, 40, 4060, 4040};   // Bins 0 and 63
        buildCluster();
        runFrame(1'b0);
        checkHand(1);
        reportTest("windowClamp", e0);
    endtask

    task automatic testOutliers();
        int e0;
        e0 = errCount;
        centers = '{720, 1616, 2512, 3344};
        buildCluster();
        // Fine pass only, three of four slots far away, aliasing onto the +0 bin if kept
        for (int i = 0; i < smpPerPass; i++) begin
            if (i % 4 != 1) begin
                fineSmp[i] = sifhDataPkg::sampleT'((centers[pixOf(i)] + 2048) % (maxS + 1));
            end
        end
        runFrame(1'b0);
        checkHand(1);
        reportTest("outliers", e0);
    endtask

    task automatic testTie();
        int e0;
        int j;
        e0 = errCount;
        centers = '{136, 1096, 2184, 3208};
        for (int i = 0; i < smpPerPass; i++) begin
            j = (i / (`SIFH_DATA_NUM * `SIFH_PIXELS)) * `SIFH_DATA_NUM + i % `SIFH_DATA_NUM;
            coarseSmp[i] = sifhDataPkg::sampleT'(centers[pixOf(i)] + tieOff(j));
            fineSmp[i]   = coarseSmp[i];
        end
        runFrame(1'b0);
        checkHand(3);
        reportTest("tieFirst", e0);
    endtask

    task automatic testRandom();
        int e0;
        int c;
        e0 = errCount;
        for (int f = 0; f < 4; f++) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                centers[p] = int'(nextRand() >> 20);
            end
            for (int i = 0; i < smpPerPass; i++) begin
                c = centers[pixOf(i)];
                // Even slots near the cluster, odd slots anywhere
                if (i % 2 == 0) begin
                    coarseSmp[i] = sifhDataPkg::sampleT'(c + int'(nextRand() >> 30));
                    fineSmp[i]   = sifhDataPkg::sampleT'(c + int'(nextRand() >> 30));
                end else begin
                    coarseSmp[i] = sifhDataPkg::sampleT'(nextRand() >> 20);
                    fineSmp[i]   = sifhDataPkg::sampleT'(nextRand() >> 20);
                end
            end
            runFrame(1'b1);   // Back to back, wrEn pulses while busy
        end
        reportTest("randomFrames", e0);
    endtask

    initial begin
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        repeat (3) @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        testReset();
        testMidCluster();
        testClamp();
        testOutliers();
        testTie();
        testRandom();
        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sifhTop.sv
// Single-pixel-group peak finder; wrEn while busy is lost, results come every second pass
`default_nettype none
`timescale 1ns/100ps

`include "sifh_defines.svh"

module sifhTop (
    input  wire                                clk,
    input  wire                                combin_res,
    input  wire                                wrEn,
    input  sifhDataPkg::sampleT                data,
    output logic                               busy,
    output sifhCtrlPkg::passT                  pass,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]   peaks,     // Pixel 0 in the low bits
    output logic                               resultValid
);

    // **************************************************
    // Internal nets
    // **************************************************
    sifhDataPkg::pixelT                   pixel;
    logic                                 accept;
    logic                                 passEnd;
    logic                                 clear;
    sifhDataPkg::binT                     bin;
    logic                                 keep;
    logic                                 cntValid;
    sifhDataPkg::pixelT                   cntPixel;
    sifhDataPkg::binT                     cntBin;
    sifhDataPkg::countT                   cnt;
    logic [`SIFH_PIXELS*`SIFH_NB-1:0]     peakBins;
    logic [`SIFH_PIXELS*`SIFH_NP-1:0]     winLow;
    logic [`SIFH_PIXELS*(`SIFH_NP+1)-1:0] winHigh;
    logic [`SIFH_PIXELS*`SIFH_NP-1:0]     offset;

    frameSequencer i_frameSequencer (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn),
        .pixel(pixel), .pass(pass), .accept(accept),
        .passEnd(passEnd), .clear(clear), .busy(busy)
    );

    dataFilter i_dataFilter (
        .data(data), .pixel(pixel), .pass(pass),
        .winLow(winLow), .winHigh(winHigh), .offset(offset),
        .bin(bin), .keep(keep)
    );

    histogramBuilder i_histogramBuilder (
        .clk(clk), .combin_res(combin_res), .accept(accept), .keep(keep),
        .bin(bin), .pixel(pixel), .clear(clear),
        .cntValid(cntValid), .cntPixel(cntPixel), .cntBin(cntBin), .cnt(cnt)
    );

    peakDetector i_peakDetector (
        .clk(clk), .combin_res(combin_res), .clear(clear),
        .cntValid(cntValid), .cntPixel(cntPixel), .cntBin(cntBin), .cnt(cnt),
        .peakBins(peakBins)
    );

    // Feeds windows back to the filter
    windowCalculator i_windowCalculator (
        .clk(clk), .combin_res(combin_res), .passEnd(passEnd), .pass(pass),
        .peakBins(peakBins), .winLow(winLow), .winHigh(winHigh), .offset(offset),
        .peaks(peaks), .resultValid(resultValid)
    );

endmodule

`default_nettype wire

//--- sifhTop_checker.sv
// Sampled on rising clk; assumes busy rises only on the last sample of a pass
`default_nettype none
`timescale 1ns/100ps

module sifhTop_checker (
    input wire               clk,
    input wire               combin_res,
    input wire               busy,
    input wire               resultValid,
    input sifhCtrlPkg::passT pass
);

    // **************************************************
    // Output strobe rules
    // **************************************************
    // Result strobe never stretches
    resultOneCycle: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
        else $error("resultValid stayed high for more than one cycle");

    // Flush window is three cycles long
    busyThreeCycles: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(busy) |-> busy ##1 busy ##1 busy ##1 !busy)
        else $error("busy did not stay high for exactly three cycles");

    // Phase flips inside the flush only
    passToggleBusy: assert property (@(posedge clk) disable iff (!combin_res)
        !$stable(pass) |-> busy)
        else $error("pass changed while busy was low");

endmodule

`default_nettype wire

//--- sifh_defines.svh
// Compile-time sizes; SIFH_NP must exceed SIFH_NB and SIFH_PIXELS stays a power of two
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// **************************************************
// Sample and bin geometry
// **************************************************
`define SIFH_NP        12                 // Raw timestamp width
`define SIFH_NB        6                  // Bin address width, coarse and fine alike

// **************************************************
// Frame layout
// **************************************************
`define SIFH_PIXELS    4                  // Pixels per frame
`define SIFH_DATA_NUM  4                  // Samples per pixel per acquisition
`define SIFH_ACQ_NUM   2                  // Acquisitions per pass

// Bin counter width
// 8 samples per pixel per pass at most, 4 bits hold that
`define SIFH_CNT_W     4

`define SIFH_BINS      (1 << `SIFH_NB)    // Bins per pixel histogram

`endif

//--- vlog.f
+incdir+.
sifhDataPkg.sv
sifhCtrlPkg.sv
frameSequencer.sv
dataFilter.sv
histogramBuilder.sv
peakDetector.sv
windowCalculator.sv
sifhTop.sv
sifhTop_checker.sv
sifhTb.sv

//--- windowCalculator.sv
// Window is SIFH_BINS samples wide around the coarse bin start; high bound may reach 2**SIFH_NP
`default_nettype none
`timescale 1ns/100ps

`include "sifh_defines.svh"

module windowCalculator (
    input  wire                                    clk,
    input  wire                                    combin_res,
    input  wire                                    passEnd,
    input  sifhCtrlPkg::passT                      pass,
    input  wire [`SIFH_PIXELS*`SIFH_NB-1:0]        peakBins,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]       winLow,
    output logic [`SIFH_PIXELS*(`SIFH_NP+1)-1:0]   winHigh,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]       offset,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]       peaks,
    output logic                                   resultValid
);

    typedef logic [`SIFH_NP:0] wideT;   // One spare bit for the top clamp

    localparam int   shift = `SIFH_NP - `SIFH_NB;
    localparam wideT halfW = wideT'(1) << (`SIFH_NB - 1);
    localparam wideT spanW = halfW << 1;
    localparam wideT maxS  = wideT'((1 << `SIFH_NP) - 1);   // Largest sample value

    wideT lowN  [`SIFH_PIXELS];
    wideT highN [`SIFH_PIXELS];

    // **************************************************
    // Window bounds from coarse peaks
    // **************************************************
    always_comb begin
        wideT center;
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            center = {1'b0, peakBins[p*`SIFH_NB +: `SIFH_NB], {shift{1'b0}}};
            if (center <= halfW) begin
                lowN[p]  = '0;                   // Clamp at zero
                highN[p] = spanW;
            end else if (center >= maxS - halfW) begin
                highN[p] = maxS + 1'b1;          // Clamp at the top
                lowN[p]  = highN[p] - spanW;
            end else begin
                lowN[p]  = center - halfW;
                highN[p] = center + halfW;
            end
        end
    end

    // **************************************************
    // Registered windows and results
    // **************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLow      <= '0;
            winHigh     <= '0;
            offset      <= '0;
            peaks       <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= passEnd && (pass == sifhCtrlPkg::passFine);
            if (passEnd && (pass == sifhCtrlPkg::passCoarse)) begin
                for (int p = 0; p < `SIFH_PIXELS; p++) begin
                    winLow[p*`SIFH_NP +: `SIFH_NP]          <= lowN[p][`SIFH_NP-1:0];
                    winHigh[p*(`SIFH_NP+1) +: (`SIFH_NP+1)] <= highN[p];
                    offset[p*`SIFH_NP +: `SIFH_NP]          <= lowN[p][`SIFH_NP-1:0];
                end
            end
            if (passEnd && (pass == sifhCtrlPkg::passFine)) begin
                // Fine bin back to absolute time
                for (int p = 0; p < `SIFH_PIXELS; p++) begin
                    peaks[p*`SIFH_NP +: `SIFH_NP] <=
                        {{shift{1'b0}}, peakBins[p*`SIFH_NB +: `SIFH_NB]} +
                        offset[p*`SIFH_NP +: `SIFH_NP];
                end
            end
        end
    end

endmodule

`default_nettype wire
